// ==== rtl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_DATA_W   32
`define CPU_REG_AW   4
`define CPU_NUM_REGS 16
`define CPU_IMM_W    14

// Instruction word layout
`define CPU_OP_HI    31
`define CPU_OP_LO    27
`define CPU_RI_BIT   26
`define CPU_DR_HI    25
`define CPU_DR_LO    22
`define CPU_SR1_HI   21
`define CPU_SR1_LO   18
`define CPU_SR2_HI   17
`define CPU_SR2_LO   14
`define CPU_IMM_HI   13
`define CPU_IMM_LO   0

`endif

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
    typedef logic [`CPU_IMM_W-1:0]  imm_t;
    typedef logic [3:0]             flags_t;

    // Bit positions inside flags_t
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    typedef enum logic [4:0] {
        OP_NOP = 5'd0,
        OP_ADD = 5'd1,
        OP_SUB = 5'd2,
        OP_AND = 5'd3,
        OP_OR  = 5'd4,
        OP_XOR = 5'd5,
        OP_SHL = 5'd6,
        OP_SHR = 5'd7,
        OP_BR  = 5'd12
    } opcode_e;

    // Unknown codes fall back to NOP
    function automatic opcode_e decode_op(logic [4:0] raw);
        case (raw)
            5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd12: return opcode_e'(raw);
            default: return OP_NOP;
        endcase
    endfunction

    // True for operations that produce a register result
    function automatic logic is_alu_op(opcode_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/instr_decode.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module instr_decode (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  wire                 i_flush,
    input  cpu_pkg::data_t      i_instr,
    input  cpu_pkg::data_t      i_pc,
    output cpu_pkg::opcode_e    o_opcode,
    output logic                o_ri,
    output cpu_pkg::reg_addr_t  o_dr,
    output cpu_pkg::reg_addr_t  o_sr1,
    output cpu_pkg::reg_addr_t  o_sr2,
    output cpu_pkg::data_t      o_imm,
    output cpu_pkg::data_t      o_pc
);
    import cpu_pkg::*;

    imm_t  imm_field;
    data_t imm_sext;

    assign imm_field = i_instr[`CPU_IMM_HI:`CPU_IMM_LO];
    assign imm_sext  = {{(`CPU_DATA_W-`CPU_IMM_W){imm_field[`CPU_IMM_W-1]}}, imm_field};

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            // Empty slot is a NOP writing nothing
            o_opcode <= OP_NOP;
            o_ri     <= 1'b0;
            o_dr     <= '0;
            o_sr1    <= '0;
            o_sr2    <= '0;
            o_imm    <= '0;
            o_pc     <= '0;
        end else if (!i_stall) begin
            o_opcode <= decode_op(i_instr[`CPU_OP_HI:`CPU_OP_LO]);
            o_ri     <= i_instr[`CPU_RI_BIT];
            o_dr     <= i_instr[`CPU_DR_HI:`CPU_DR_LO];   // Branch mask for OP_BR
            o_sr1    <= i_instr[`CPU_SR1_HI:`CPU_SR1_LO];
            o_sr2    <= i_instr[`CPU_SR2_HI:`CPU_SR2_LO];
            o_imm    <= imm_sext;
            o_pc     <= i_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module register_file (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_we,
    input  cpu_pkg::reg_addr_t  i_wa,
    input  cpu_pkg::data_t      i_wd,
    input  cpu_pkg::reg_addr_t  i_ra1,
    input  cpu_pkg::reg_addr_t  i_ra2,
    output cpu_pkg::data_t      o_rd1,
    output cpu_pkg::data_t      o_rd2
);
    import cpu_pkg::*;

    data_t regs [`CPU_NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin // r0 never written
            regs[i_wa] <= i_wd;
        end
    end

    // Asynchronous read, r0 forced to zero
    assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

endmodule

`default_nettype wire

// ==== rtl/register_read.sv ====
`default_nettype none

module register_read (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  wire                 i_flush,
    // Decode buffer
    input  cpu_pkg::opcode_e    i_opcode,
    input  wire                 i_ri,
    input  cpu_pkg::reg_addr_t  i_dr,
    input  cpu_pkg::reg_addr_t  i_sr1,
    input  cpu_pkg::reg_addr_t  i_sr2,
    input  cpu_pkg::data_t      i_imm,
    input  cpu_pkg::data_t      i_pc,
    // Register file ports
    output cpu_pkg::reg_addr_t  o_rf_ra1,
    output cpu_pkg::reg_addr_t  o_rf_ra2,
    input  cpu_pkg::data_t      i_rf_rd1,
    input  cpu_pkg::data_t      i_rf_rd2,
    // Forwarding buses, bus 1 ahead of the execute buffer, bus 2 at it
    input  cpu_pkg::reg_addr_t  i_fwd1_reg,
    input  cpu_pkg::data_t      i_fwd1_data,
    input  cpu_pkg::reg_addr_t  i_fwd2_reg,
    input  cpu_pkg::data_t      i_fwd2_data,
    // Stage buffer
    output cpu_pkg::opcode_e    o_opcode,
    output cpu_pkg::reg_addr_t  o_dr,
    output cpu_pkg::flags_t     o_flags_mask,
    output cpu_pkg::data_t      o_sr1_val,
    output cpu_pkg::data_t      o_sr2_val,
    output cpu_pkg::data_t      o_target_offset,
    output cpu_pkg::data_t      o_pc
);
    import cpu_pkg::*;

    logic  is_branch;
    data_t sr1_next;
    data_t sr2_next;

    // Newest producer wins over the older one
    function automatic data_t pick_operand(reg_addr_t src, data_t rf_data);
        if (src == '0) begin
            return rf_data;   // Register file gives zero here
        end else if (src == i_fwd1_reg) begin
            return i_fwd1_data;
        end else if (src == i_fwd2_reg) begin
            return i_fwd2_data;
        end
        return rf_data;
    endfunction

    assign o_rf_ra1  = i_sr1;
    assign o_rf_ra2  = i_sr2;
    assign is_branch = (i_opcode == OP_BR);

    assign sr1_next = pick_operand(i_sr1, i_rf_rd1);
    assign sr2_next = i_ri ? i_imm : pick_operand(i_sr2, i_rf_rd2);

    always_ff @(posedge i_clk) begin
        if (i_reset || i_flush) begin
            o_opcode        <= OP_NOP;
            o_dr            <= '0;
            o_flags_mask    <= '0;
            o_sr1_val       <= '0;
            o_sr2_val       <= '0;
            o_target_offset <= '0;
            o_pc            <= '0;
        end else if (!i_stall) begin
            o_opcode        <= i_opcode;
            // dr field is the condition mask for a branch
            o_dr            <= is_branch ? '0 : i_dr;
            o_flags_mask    <= is_branch ? flags_t'(i_dr) : '0;
            o_sr1_val       <= sr1_next;
            o_sr2_val       <= sr2_next;
            o_target_offset <= i_imm;
            o_pc            <= i_pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/alu_execute.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module alu_execute (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    // Register-read buffer
    input  cpu_pkg::opcode_e    i_opcode,
    input  cpu_pkg::reg_addr_t  i_dr,
    input  cpu_pkg::flags_t     i_flags_mask,
    input  cpu_pkg::data_t      i_sr1_val,
    input  cpu_pkg::data_t      i_sr2_val,
    input  cpu_pkg::data_t      i_target_offset,
    input  cpu_pkg::data_t      i_pc,
    // Forwarding bus 1
    output cpu_pkg::reg_addr_t  o_fwd1_reg,
    output cpu_pkg::data_t      o_fwd1_data,
    // Execute output buffer and register file write strobe
    output logic                o_wb_en,
    output cpu_pkg::reg_addr_t  o_wb_reg,
    output cpu_pkg::data_t      o_wb_data,
    output logic                o_rf_we,
    // Branch resolution
    output logic                o_branch_taken,
    output cpu_pkg::data_t      o_branch_target
);
    import cpu_pkg::*;

    data_t  result;
    logic   carry;
    logic   ovf;
    flags_t flags_q;
    flags_t flags_next;
    logic   writes;
    logic   cond_met;
    logic   [`CPU_DATA_W:0] sum_ext;
    logic   [`CPU_DATA_W:0] diff_ext;

    assign sum_ext  = {1'b0, i_sr1_val} + {1'b0, i_sr2_val};
    assign diff_ext = {1'b0, i_sr1_val} + {1'b0, ~i_sr2_val} + 1'b1; // Carry set means no borrow

    always_comb begin
        result = '0;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (i_opcode)
            OP_ADD: begin
                result = sum_ext[`CPU_DATA_W-1:0];
                carry  = sum_ext[`CPU_DATA_W];
                ovf    = (i_sr1_val[`CPU_DATA_W-1] == i_sr2_val[`CPU_DATA_W-1]) &&
                         (result[`CPU_DATA_W-1] != i_sr1_val[`CPU_DATA_W-1]);
            end
            OP_SUB: begin
                result = diff_ext[`CPU_DATA_W-1:0];
                carry  = diff_ext[`CPU_DATA_W];
                ovf    = (i_sr1_val[`CPU_DATA_W-1] != i_sr2_val[`CPU_DATA_W-1]) &&
                         (result[`CPU_DATA_W-1] != i_sr1_val[`CPU_DATA_W-1]);
            end
            OP_AND: result = i_sr1_val & i_sr2_val;
            OP_OR:  result = i_sr1_val | i_sr2_val;
            OP_XOR: result = i_sr1_val ^ i_sr2_val;
            OP_SHL: result = i_sr1_val << i_sr2_val[4:0];
            OP_SHR: result = i_sr1_val >> i_sr2_val[4:0];
            default: result = '0;                      // NOP and branch
        endcase
    end

    always_comb begin
        flags_next         = '0;
        flags_next[FLAG_Z] = (result == '0);
        flags_next[FLAG_N] = result[`CPU_DATA_W-1];
        flags_next[FLAG_C] = carry;
        flags_next[FLAG_V] = ovf;
    end

    assign writes = is_alu_op(i_opcode) && (i_dr != '0);

    assign o_fwd1_reg  = writes ? i_dr : '0;
    assign o_fwd1_data = result;

    // Empty mask means always taken
    assign cond_met        = (i_flags_mask == '0) || ((i_flags_mask & flags_q) != '0);
    assign o_branch_taken  = (i_opcode == OP_BR) && cond_met && !i_stall;
    assign o_branch_target = i_pc + i_target_offset;

    assign o_rf_we = o_wb_en && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            flags_q   <= '0;
            o_wb_en   <= 1'b0;
            o_wb_reg  <= '0;
            o_wb_data <= '0;
        end else if (!i_stall) begin
            if (writes) begin
                flags_q <= flags_next;
            end
            o_wb_en   <= writes;
            o_wb_reg  <= writes ? i_dr : '0;   // Bus 2 reads as r0 when idle
            o_wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`default_nettype none

module cpu_core (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  cpu_pkg::data_t      i_instr,
    input  cpu_pkg::data_t      i_pc,
    output logic                o_wb_en,
    output cpu_pkg::reg_addr_t  o_wb_reg,
    output cpu_pkg::data_t      o_wb_data,
    output logic                o_branch_taken,
    output cpu_pkg::data_t      o_branch_target
);
    import cpu_pkg::*;

    // Decode buffer
    opcode_e   id_opcode;
    logic      id_ri;
    reg_addr_t id_dr;
    reg_addr_t id_sr1;
    reg_addr_t id_sr2;
    data_t     id_imm;
    data_t     id_pc;

    // Register file ports
    reg_addr_t rf_ra1;
    reg_addr_t rf_ra2;
    data_t     rf_rd1;
    data_t     rf_rd2;
    logic      rf_we;

    // Register-read buffer
    opcode_e   rr_opcode;
    reg_addr_t rr_dr;
    flags_t    rr_flags_mask;
    data_t     rr_sr1_val;
    data_t     rr_sr2_val;
    data_t     rr_target_offset;
    data_t     rr_pc;

    reg_addr_t fwd1_reg;
    data_t     fwd1_data;

    instr_decode instr_decode_inst (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_stall  (i_stall),
        .i_flush  (o_branch_taken),
        .i_instr  (i_instr),
        .i_pc     (i_pc),
        .o_opcode (id_opcode),
        .o_ri     (id_ri),
        .o_dr     (id_dr),
        .o_sr1    (id_sr1),
        .o_sr2    (id_sr2),
        .o_imm    (id_imm),
        .o_pc     (id_pc)
    );

    register_read register_read_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_stall         (i_stall),
        .i_flush         (o_branch_taken),
        .i_opcode        (id_opcode),
        .i_ri            (id_ri),
        .i_dr            (id_dr),
        .i_sr1           (id_sr1),
        .i_sr2           (id_sr2),
        .i_imm           (id_imm),
        .i_pc            (id_pc),
        .o_rf_ra1        (rf_ra1),
        .o_rf_ra2        (rf_ra2),
        .i_rf_rd1        (rf_rd1),
        .i_rf_rd2        (rf_rd2),
        .i_fwd1_reg      (fwd1_reg),
        .i_fwd1_data     (fwd1_data),
        .i_fwd2_reg      (o_wb_reg),     // Bus 2 is the execute buffer
        .i_fwd2_data     (o_wb_data),
        .o_opcode        (rr_opcode),
        .o_dr            (rr_dr),
        .o_flags_mask    (rr_flags_mask),
        .o_sr1_val       (rr_sr1_val),
        .o_sr2_val       (rr_sr2_val),
        .o_target_offset (rr_target_offset),
        .o_pc            (rr_pc)
    );

    register_file register_file_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_we    (rf_we),
        .i_wa    (o_wb_reg),
        .i_wd    (o_wb_data),
        .i_ra1   (rf_ra1),
        .i_ra2   (rf_ra2),
        .o_rd1   (rf_rd1),
        .o_rd2   (rf_rd2)
    );

    alu_execute alu_execute_inst (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_stall         (i_stall),
        .i_opcode        (rr_opcode),
        .i_dr            (rr_dr),
        .i_flags_mask    (rr_flags_mask),
        .i_sr1_val       (rr_sr1_val),
        .i_sr2_val       (rr_sr2_val),
        .i_target_offset (rr_target_offset),
        .i_pc            (rr_pc),
        .o_fwd1_reg      (fwd1_reg),
        .o_fwd1_data     (fwd1_data),
        .o_wb_en         (o_wb_en),
        .o_wb_reg        (o_wb_reg),
        .o_wb_data       (o_wb_data),
        .o_rf_we         (rf_we),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target)
    );

endmodule

`default_nettype wire

// ==== verification/cpu_core_properties.sv ====
`default_nettype none

module cpu_core_properties (
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire                 i_stall,
    input  wire                 i_wb_en,
    input  cpu_pkg::reg_addr_t  i_wb_reg,
    input  cpu_pkg::data_t      i_wb_data,
    input  wire                 i_branch_taken
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // Failed assertions so far

    // A write-back always names a real register
    wb_reg_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_en |-> (i_wb_reg != '0))
        else begin
            $error("write-back enabled with register 0");
            fail_count++;
        end

    stall_holds_wb: assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |=> ($stable(i_wb_en) && $stable(i_wb_reg) && $stable(i_wb_data)))
        else begin
            $error("execute output buffer changed during a stall");
            fail_count++;
        end

    // Both flushed slots leave the buffer idle after the branch itself
    flush_no_wb: assert property (@(posedge i_clk) disable iff (i_reset)
        i_branch_taken |=> ##1 !i_wb_en ##1 !i_wb_en)
        else begin
            $error("flushed instruction reached write-back");
            fail_count++;
        end

endmodule

bind cpu_core cpu_core_properties cpu_core_properties_inst (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_stall        (i_stall),
    .i_wb_en        (o_wb_en),
    .i_wb_reg       (o_wb_reg),
    .i_wb_data      (o_wb_data),
    .i_branch_taken (o_branch_taken)
);

`default_nettype wire

// ==== verification/tb_cpu_core.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module tb_cpu_core;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    localparam int    PROG_LEN      = 200;
    localparam int    DRAIN_LIMIT   = 50;
    localparam int    MAX_STALL_RUN = 8;
    localparam data_t NOP_WORD      = '0;

    logic      clk;
    logic      reset;
    logic      stall;
    data_t     instr;
    data_t     pc;
    logic      wb_en;
    reg_addr_t wb_reg;
    data_t     wb_data;
    logic      branch_taken;
    data_t     branch_target;

    // Reference model, updated in program order
    data_t     ref_regs [`CPU_NUM_REGS];
    flags_t    ref_flags;
    int        squash_left;
    reg_addr_t exp_wb_reg [$];
    data_t     exp_wb_data [$];
    data_t     exp_target [$];

    integer    seed;
    data_t     next_pc;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        start_errors;

    cpu_core cpu_core_inst (
        .i_clk           (clk),
        .i_reset         (reset),
        .i_stall         (stall),
        .i_instr         (instr),
        .i_pc            (pc),
        .o_wb_en         (wb_en),
        .o_wb_reg        (wb_reg),
        .o_wb_data       (wb_data),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic data_t encode_instr(logic [4:0] op, logic ri, reg_addr_t dr,
                                           reg_addr_t s1, reg_addr_t s2, logic [13:0] imm);
        return {op, ri, dr, s1, s2, imm};
    endfunction

    function automatic data_t alu_rr(opcode_e op, reg_addr_t dr, reg_addr_t s1, reg_addr_t s2);
        return encode_instr(op, 1'b0, dr, s1, s2, 14'd0);
    endfunction

    function automatic data_t alu_ri(opcode_e op, reg_addr_t dr, reg_addr_t s1, int imm);
        return encode_instr(op, 1'b1, dr, s1, 4'd0, imm[13:0]);
    endfunction

    function automatic data_t branch_instr(flags_t mask, int offset);
        return encode_instr(OP_BR, 1'b0, mask, 4'd0, 4'd0, offset[13:0]);
    endfunction

    // Flags are Z N C V from bit 3 down
    function automatic data_t ref_alu(logic [4:0] op, data_t a, data_t b, output flags_t fl);
        longint sum;
        data_t  res;
        fl  = '0;
        res = '0;
        sum = 0;
        case (op)
            OP_ADD: begin
                res   = a + b;
                sum   = longint'(signed'(a)) + longint'(signed'(b));
                fl[1] = (64'(a) + 64'(b)) > 64'hFFFF_FFFF;
            end
            OP_SUB: begin
                res   = a - b;
                sum   = longint'(signed'(a)) - longint'(signed'(b));
                fl[1] = (a >= b);                    // No borrow
            end
            OP_AND: res = a & b;
            OP_OR:  res = a | b;
            OP_XOR: res = a ^ b;
            OP_SHL: res = a << b[4:0];
            OP_SHR: res = a >> b[4:0];
            default: res = '0;
        endcase
        fl[0] = (sum > 64'sd2147483647) || (sum < -64'sd2147483648);
        fl[3] = (res == '0);
        fl[2] = res[31];
        return res;
    endfunction

    function automatic void apply_model(data_t word, data_t word_pc);
        logic [4:0] op;
        reg_addr_t  dr;
        data_t      a;
        data_t      b;
        data_t      imm;
        data_t      res;
        flags_t     fl;
        if (squash_left > 0) begin
            squash_left--;                          // Younger than a taken branch
            return;
        end
        op  = word[`CPU_OP_HI:`CPU_OP_LO];
        dr  = word[`CPU_DR_HI:`CPU_DR_LO];
        imm = {{18{word[13]}}, word[13:0]};
        a   = ref_regs[word[`CPU_SR1_HI:`CPU_SR1_LO]];
        b   = word[`CPU_RI_BIT] ? imm : ref_regs[word[`CPU_SR2_HI:`CPU_SR2_LO]];
        if (op >= OP_ADD && op <= OP_SHR) begin
            res = ref_alu(op, a, b, fl);
            if (dr != '0) begin
                ref_regs[dr] = res;
                ref_flags    = fl;
                exp_wb_reg.push_back(dr);
                exp_wb_data.push_back(res);
            end
        end else if (op == OP_BR) begin
            if (dr == '0 || (dr & ref_flags) != '0) begin
                exp_target.push_back(word_pc + imm);
                squash_left = 2;
            end
        end
    endfunction

    function automatic logic pick_stall(int pct);
        return (pct > 0) && (({$random(seed)} % 100) < pct);
    endfunction

    // Hold the word on the input until an unstalled edge takes it
    task automatic issue(data_t word, int stall_pct);
        logic stalled;
        int   tries;
        tries = 0;
        instr <= word;
        pc    <= next_pc;
        do begin
            stalled = pick_stall(stall_pct) && (tries < MAX_STALL_RUN);
            stall <= stalled;
            @(posedge clk);
            tries++;
        end while (stalled);
        apply_model(word, next_pc);
        next_pc = next_pc + 4;
    endtask

    task automatic issue_spaced(data_t word);
        issue(word, 0);
        repeat (3) issue(NOP_WORD, 0);
    endtask

    function automatic void report_mismatch(string name, data_t expected, data_t actual);
        $display("[ERROR] %0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        errors++;
    endfunction

    function automatic int error_total();
        return errors + cpu_core_inst.cpu_core_properties_inst.fail_count;
    endfunction

    always @(negedge clk) begin
        if (!reset && wb_en && !stall) begin
            if (exp_wb_reg.size() == 0) begin
                $display("Unexpected write-back to r%0d at %0t", wb_reg, $time);
                errors++;
            end else begin
                assert (wb_reg == exp_wb_reg[0])
                    else report_mismatch("o_wb_reg", data_t'(exp_wb_reg[0]), data_t'(wb_reg));
                assert (wb_data == exp_wb_data[0])
                    else report_mismatch("o_wb_data", exp_wb_data[0], wb_data);
                void'(exp_wb_reg.pop_front());
                void'(exp_wb_data.pop_front());
            end
        end
        if (!reset && branch_taken) begin
            if (exp_target.size() == 0) begin
                $display("Unexpected taken branch at %0t", $time);
                errors++;
            end else begin
                assert (branch_target == exp_target[0])
                    else report_mismatch("o_branch_target", exp_target[0], branch_target);
                void'(exp_target.pop_front());
            end
        end
    end

    // Feed NOPs until every expected event has shown up
    task automatic drain(string name);
        int cycles;
        cycles = 0;
        while ((exp_wb_reg.size() != 0 || exp_target.size() != 0 || squash_left != 0) &&
               cycles < DRAIN_LIMIT) begin
            issue(NOP_WORD, 0);
            cycles++;
        end
        if (exp_wb_reg.size() != 0 || exp_target.size() != 0) begin
            $display("Timeout in %s: expected write-backs or branches never appeared", name);
            errors++;
        end
        repeat (4) issue(NOP_WORD, 0);              // Room for a stray write-back
    endtask

    task automatic finish_test(string name);
        drain(name);
        tests_run++;
        if (error_total() == start_errors) begin
            $display("Test %s: PASS", name);
        end else begin
            $display("Test %s: FAIL", name);
            tests_failed++;
        end
        start_errors = error_total();
    endtask

    task automatic test_alu_ops();
        issue_spaced(alu_ri(OP_ADD, 4'd1, 4'd0, 1234));
        issue_spaced(alu_ri(OP_ADD, 4'd2, 4'd0, -7));
        issue_spaced(alu_rr(OP_ADD, 4'd3, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_SUB, 4'd4, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_AND, 4'd5, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_OR,  4'd6, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_XOR, 4'd7, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_SHL, 4'd8, 4'd1, 4'd2));
        issue_spaced(alu_rr(OP_SHR, 4'd9, 4'd2, 4'd1));
        issue_spaced(encode_instr(5'd9, 1'b0, 4'd10, 4'd1, 4'd2, 14'd0));  // Unknown code
        issue_spaced(alu_rr(OP_ADD, 4'd11, 4'd10, 4'd9));
    endtask

    task automatic test_forwarding();
        issue(alu_ri(OP_ADD, 4'd1, 4'd0, 5), 0);
        issue(alu_rr(OP_ADD, 4'd2, 4'd1, 4'd1), 0);     // Distance 1, same source twice
        issue(alu_rr(OP_SUB, 4'd3, 4'd2, 4'd1), 0);     // Buses 1 and 2
        issue(alu_rr(OP_XOR, 4'd4, 4'd1, 4'd3), 0);
        issue(alu_ri(OP_ADD, 4'd5, 4'd0, 10), 0);
        issue(alu_ri(OP_ADD, 4'd5, 4'd0, 20), 0);
        issue(alu_rr(OP_OR,  4'd6, 4'd5, 4'd0), 0);     // Newer r5 must win
        issue(alu_ri(OP_ADD, 4'd7, 4'd0, 3), 0);
        issue(NOP_WORD, 0);
        issue(alu_rr(OP_SHL, 4'd8, 4'd7, 4'd7), 0);     // Distance 2 only
    endtask

    task automatic test_imm_r0();
        issue(alu_ri(OP_ADD, 4'd5, 4'd0, -1), 0);
        issue(alu_ri(OP_AND, 4'd6, 4'd5, 'h2000), 0);   // Sign bit of immediate set
        issue(alu_rr(OP_XOR, 4'd0, 4'd5, 4'd6), 0);     // Dropped write
        issue(alu_rr(OP_ADD, 4'd7, 4'd0, 4'd5), 0);
        issue(alu_ri(OP_OR,  4'd8, 4'd0, 'h1fff), 0);
        issue(encode_instr(OP_ADD, 1'b1, 4'd10, 4'd8, 4'd8, 14'd3), 0);
        issue(alu_rr(OP_SUB, 4'd9, 4'd0, 4'd0), 0);
    endtask

    task automatic test_branches();
        issue(alu_rr(OP_SUB, 4'd1, 4'd2, 4'd2), 0);     // Z and C
        issue(branch_instr(4'b0000, 16), 0);
        issue(alu_ri(OP_ADD, 4'd3, 4'd0, 111), 0);
        issue(alu_ri(OP_ADD, 4'd4, 4'd0, 222), 0);
        issue(branch_instr(4'b1000, -32), 0);           // Z matches
        issue(branch_instr(4'b0000, 12), 0);            // Squashed branch
        issue(alu_ri(OP_ADD, 4'd4, 4'd0, 2), 0);
        issue(branch_instr(4'b0101, 64), 0);            // N and V clear
        issue(alu_ri(OP_ADD, 4'd3, 4'd0, -3), 0);
        issue(branch_instr(4'b0100, -100), 0);
        issue(alu_ri(OP_ADD, 4'd4, 4'd0, 7), 0);
        issue(alu_ri(OP_ADD, 4'd5, 4'd0, 8), 0);
        issue(alu_ri(OP_ADD, 4'd6, 4'd0, 9), 0);
    endtask

    task automatic test_random();
        data_t word;
        int    kind;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = {$random(seed)} % 10;
            word = $random(seed);
            if (kind == 0) begin
                word[31:27] = OP_BR;
            end else if (kind == 1) begin
                word[31:27] = 5'd9;
            end else begin
                word[31:27] = 5'd1 + ({$random(seed)} % 7);
            end
            issue(word, 20);
        end
    endtask

    initial begin
        seed         = 32'hce3f_9924;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        start_errors = 0;
        reset        = 1'b1;
        stall        = 1'b0;
        instr        = '0;
        pc           = '0;
        next_pc      = 32'h0000_1000;
        ref_flags    = '0;
        squash_left  = 0;
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        test_alu_ops();
        finish_test("alu_ops");
        test_forwarding();
        finish_test("forwarding");
        test_imm_r0();
        finish_test("immediate_r0");
        test_branches();
        finish_test("branches");
        test_random();
        finish_test("random_stall");

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/register_read.sv
rtl/alu_execute.sv
rtl/cpu_core.sv
verification/cpu_core_properties.sv
verification/tb_cpu_core.sv
